// File: hw/slot_adc_pkg.sv
`default_nettype none

package slot_adc_pkg;

    // Converter sample and output word widths
    localparam int SAMPLE_W     = 24;
    localparam int AUDIO_WORD_W = 32;

    // Command bytes and the acon register share this width
    localparam int CMD_W = 8;

    // Bit position counter inside one LRCK half frame
    localparam int BIT_COUNT_W = 6;

    // Sample FIFO geometry
    localparam int FIFO_DEPTH   = 16;
    localparam int FIFO_COUNT_W = 5;

    // One-byte command codes
    localparam logic [CMD_W-1:0] CMD_START_RECORDING = 8'h10;
    localparam logic [CMD_W-1:0] CMD_STOP_RECORDING  = 8'h11;
    // Followed by one parameter byte
    localparam logic [CMD_W-1:0] CMD_SET_ACON        = 8'h12;

    // Converter control defaults
    localparam logic [CMD_W-1:0] ACON_RESET = 8'h51;

endpackage

`default_nettype wire

// File: hw/i2s_capture.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_capture (
    input  logic                              adc_pbck,
    input  logic                              reset,
    input  logic                              adc_plrck,
    input  logic                              adc_pdata,
    output logic                              word_valid,
    output logic [slot_adc_pkg::SAMPLE_W-1:0] word_data,
    output logic                              word_is_left
);
    import slot_adc_pkg::*;

    // Position 1 holds the MSB, position SAMPLE_W the LSB
    localparam logic [BIT_COUNT_W-1:0] FIRST_POS = BIT_COUNT_W'(1);
    localparam logic [BIT_COUNT_W-1:0] LSB_POS   = BIT_COUNT_W'(SAMPLE_W);
    // Counter parks here once the word is complete
    localparam logic [BIT_COUNT_W-1:0] IDLE_POS  = BIT_COUNT_W'(SAMPLE_W + 1);

    logic                   lrck_prev;
    logic                   lrck_seen;
    logic [BIT_COUNT_W-1:0] bit_pos;
    logic [SAMPLE_W-1:0]    shift_reg;
    logic                   lrck_change;
    logic                   bit_in_word;

    // Edge that first samples a new LRCK level is position 0
    assign lrck_change = (adc_plrck != lrck_prev);
    assign bit_in_word = (bit_pos >= FIRST_POS) && (bit_pos <= LSB_POS);

    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            // Track the line during reset so the first change seen is a real one
            lrck_prev  <= adc_plrck;
            lrck_seen  <= 1'b0;
            bit_pos    <= IDLE_POS;
            word_valid <= 1'b0;
        end else begin
            lrck_prev <= adc_plrck;
            // The half frame in progress at reset release is incomplete
            word_valid <= lrck_change && lrck_seen;
            if (lrck_change) begin
                lrck_seen <= 1'b1;
                bit_pos   <= FIRST_POS;
            end else if (bit_pos != IDLE_POS) begin
                bit_pos <= bit_pos + 1'b1;
            end
        end
    end

    // Word assembly
    always_ff @(posedge adc_pbck) begin
        if (lrck_change) begin
            word_data    <= shift_reg;
            // LRCK low carried the left channel
            word_is_left <= !lrck_prev;
            shift_reg    <= '0;
        end else if (bit_in_word) begin
            shift_reg <= {shift_reg[SAMPLE_W-2:0], adc_pdata};
        end
    end

endmodule

`default_nettype wire

// File: hw/record_gate.sv
`timescale 1ns/1ps
`default_nettype none

module record_gate (
    input  logic                                  adc_pbck,
    input  logic                                  reset,
    input  logic                                  record_request,
    input  logic                                  word_valid,
    input  logic [slot_adc_pkg::SAMPLE_W-1:0]     word_data,
    input  logic                                  word_is_left,
    output logic                                  push,
    output logic [slot_adc_pkg::AUDIO_WORD_W-1:0] push_data
);
    import slot_adc_pkg::*;

    localparam int PAD_W = AUDIO_WORD_W - SAMPLE_W;

    logic enable;
    logic admit;

    // A left word takes the request directly, its right partner
    // follows whatever the left word was given
    always_comb begin
        if (word_is_left) begin
            admit = record_request;
        end else begin
            admit = enable;
        end
    end

    assign push      = word_valid && admit;
    assign push_data = {{PAD_W{1'b0}}, word_data};

    // Enable only moves on left words so a pair is never split
    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            enable <= 1'b0;
        end else if (word_valid && word_is_left) begin
            enable <= record_request;
        end
    end

endmodule

`default_nettype wire

// File: hw/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo (
    input  logic                                  adc_pbck,
    input  logic                                  reset,
    input  logic                                  push,
    input  logic [slot_adc_pkg::AUDIO_WORD_W-1:0] push_data,
    output logic                                  aud_valid,
    output logic [slot_adc_pkg::AUDIO_WORD_W-1:0] aud_data,
    input  logic                                  aud_ready,
    output logic                                  overflow
);
    import slot_adc_pkg::*;

    // Depth is a power of two so the pointers wrap on their own
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [FIFO_COUNT_W-1:0] FULL_COUNT = FIFO_COUNT_W'(FIFO_DEPTH);

    logic [AUDIO_WORD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [FIFO_COUNT_W-1:0] count;
    logic                    full;
    logic                    wr_en;
    logic                    rd_en;

    assign full  = (count == FULL_COUNT);
    // Samples arrive in real time, so a push into a full buffer is lost
    assign wr_en = push && !full;
    assign rd_en = aud_valid && aud_ready;

    // Head entry stays put until popped
    assign aud_valid = (count != '0);
    assign aud_data  = mem[rd_ptr];

    always_ff @(posedge adc_pbck) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky until reset
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/slot_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module slot_cmd_decoder (
    input  logic                           adc_pbck,
    input  logic                           reset,
    input  logic                           ctl_valid,
    input  logic [slot_adc_pkg::CMD_W-1:0] ctl_data,
    output logic                           record_request,
    output logic [slot_adc_pkg::CMD_W-1:0] acon
);
    import slot_adc_pkg::*;

    // Low while waiting for a command code, high on its parameter byte
    logic             byte_pos;
    logic [CMD_W-1:0] cur_cmd;

    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            byte_pos       <= 1'b0;
            cur_cmd        <= '0;
            record_request <= 1'b0;
            acon           <= ACON_RESET;
        end else if (ctl_valid) begin
            if (!byte_pos) begin
                case (ctl_data)
                    CMD_START_RECORDING: begin
                        record_request <= 1'b1;
                    end
                    CMD_STOP_RECORDING: begin
                        record_request <= 1'b0;
                    end
                    CMD_SET_ACON: begin
                        cur_cmd  <= ctl_data;
                        byte_pos <= 1'b1;
                    end
                    // Unknown codes are dropped
                    default: begin
                        byte_pos <= 1'b0;
                    end
                endcase
            end else begin
                if (cur_cmd == CMD_SET_ACON) begin
                    acon <= ctl_data;
                end
                byte_pos <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/slot_adc_rx.sv
`timescale 1ns/1ps
`default_nettype none

module slot_adc_rx (
    input  logic                                  adc_pbck,
    input  logic                                  reset,
    input  logic                                  ctl_valid,
    input  logic [slot_adc_pkg::CMD_W-1:0]        ctl_data,
    input  logic                                  adc_plrck,
    input  logic                                  adc_pdata,
    output logic                                  aud_valid,
    output logic [slot_adc_pkg::AUDIO_WORD_W-1:0] aud_data,
    input  logic                                  aud_ready,
    output logic [slot_adc_pkg::CMD_W-1:0]        acon,
    output logic                                  overflow
);
    import slot_adc_pkg::*;

    logic                    record_request;
    logic                    word_valid;
    logic [SAMPLE_W-1:0]     word_data;
    logic                    word_is_left;
    logic                    push;
    logic [AUDIO_WORD_W-1:0] push_data;

    slot_cmd_decoder u_cmd_decoder (
        .adc_pbck       (adc_pbck),
        .reset          (reset),
        .ctl_valid      (ctl_valid),
        .ctl_data       (ctl_data),
        .record_request (record_request),
        .acon           (acon)
    );

    // Serial converter data to 24-bit channel words
    i2s_capture u_capture (
        .adc_pbck     (adc_pbck),
        .reset        (reset),
        .adc_plrck    (adc_plrck),
        .adc_pdata    (adc_pdata),
        .word_valid   (word_valid),
        .word_data    (word_data),
        .word_is_left (word_is_left)
    );

    record_gate u_gate (
        .adc_pbck       (adc_pbck),
        .reset          (reset),
        .record_request (record_request),
        .word_valid     (word_valid),
        .word_data      (word_data),
        .word_is_left   (word_is_left),
        .push           (push),
        .push_data      (push_data)
    );

    sample_fifo u_fifo (
        .adc_pbck  (adc_pbck),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .aud_valid (aud_valid),
        .aud_data  (aud_data),
        .aud_ready (aud_ready),
        .overflow  (overflow)
    );

endmodule

`default_nettype wire

// File: tests/slot_adc_rx_checker.sv
`timescale 1ns/1ps
`default_nettype none

module slot_adc_rx_checker (
    input logic                                  adc_pbck,
    input logic                                  reset,
    input logic                                  aud_valid,
    input logic [slot_adc_pkg::AUDIO_WORD_W-1:0] aud_data,
    input logic                                  aud_ready,
    input logic [slot_adc_pkg::FIFO_COUNT_W-1:0] count
);
    import slot_adc_pkg::*;

    // Number of assertion failures so far
    int unsigned assert_failures = 0;

    // A stalled output word must hold
    stall_hold: assert property (@(posedge adc_pbck) disable iff (reset)
        (aud_valid && !aud_ready) |=> $stable(aud_data))
    else begin
        $error("aud_data changed while aud_valid was high and aud_ready low");
        assert_failures++;
    end

    count_limit: assert property (@(posedge adc_pbck) disable iff (reset)
        count <= FIFO_COUNT_W'(FIFO_DEPTH))
    else begin
        $error("FIFO count %0d is above the depth", count);
        assert_failures++;
    end

    // Empty from the cycle after any reset edge
    empty_in_reset: assert property (@(posedge adc_pbck)
        reset |=> !aud_valid)
    else begin
        $error("aud_valid is high during reset");
        assert_failures++;
    end

endmodule

bind sample_fifo slot_adc_rx_checker u_checker (
    .adc_pbck  (adc_pbck),
    .reset     (reset),
    .aud_valid (aud_valid),
    .aud_data  (aud_data),
    .aud_ready (aud_ready),
    .count     (count)
);

`default_nettype wire

// File: tests/slot_adc_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module slot_adc_rx_tb;
    import slot_adc_pkg::*;

    localparam int HALF_CYCLES  = 32;
    localparam int FRAME_CYCLES = 2 * HALF_CYCLES;
    localparam int NUM_PAIRS    = 8;
    // 1 idle frame, 8 table frames, 9 stalled frames, 3 after stop, 2 quiet frames
    localparam int NUM_FRAMES     = 23;
    localparam int TIMEOUT_CYCLES = 2 * NUM_FRAMES * FRAME_CYCLES + 500;
    localparam int PAD_W          = AUDIO_WORD_W - SAMPLE_W;

    logic                    adc_pbck;
    logic                    reset;
    logic                    ctl_valid;
    logic [CMD_W-1:0]        ctl_data;
    logic                    adc_plrck;
    logic                    adc_pdata;
    logic                    aud_valid;
    logic [AUDIO_WORD_W-1:0] aud_data;
    logic                    aud_ready;
    logic [CMD_W-1:0]        acon;
    logic                    overflow;

    // Stimulus table with one left/right pair per row
    logic [SAMPLE_W-1:0]     stim_left [NUM_PAIRS];
    logic [SAMPLE_W-1:0]     stim_right [NUM_PAIRS];

    logic [AUDIO_WORD_W-1:0] got_q [$];
    logic [AUDIO_WORD_W-1:0] exp_q [$];
    int                      cycle_count = 0;
    integer                  seed;

    slot_adc_rx DUT (
        .adc_pbck  (adc_pbck),
        .reset     (reset),
        .ctl_valid (ctl_valid),
        .ctl_data  (ctl_data),
        .adc_plrck (adc_plrck),
        .adc_pdata (adc_pdata),
        .aud_valid (aud_valid),
        .aud_data  (aud_data),
        .aud_ready (aud_ready),
        .acon      (acon),
        .overflow  (overflow)
    );

    always #5 adc_pbck = ~adc_pbck;

    task automatic fail_run(input string what);
        $display("%s at time %0t", what, $time);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Sink samples mid-cycle where outputs and aud_ready are settled
    always @(negedge adc_pbck) begin
        if (!reset && aud_valid && aud_ready) begin
            got_q.push_back(aud_data);
        end
    end

    always @(negedge adc_pbck) begin
        if (DUT.u_fifo.u_checker.assert_failures != 0) begin
            fail_run("A FIFO handshake assertion failed");
        end
    end

    always @(posedge adc_pbck) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run("Run did not finish within the cycle limit");
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge adc_pbck);
        #1;
    endtask

    task automatic wait_fifo_empty();
        @(posedge adc_pbck);
        #1;
        while (aud_valid) begin
            @(posedge adc_pbck);
            #1;
        end
    endtask

    task automatic send_byte(input logic [CMD_W-1:0] value);
        @(posedge adc_pbck);
        #1;
        ctl_valid = 1'b1;
        ctl_data  = value;
    endtask

    task automatic end_cmd();
        @(posedge adc_pbck);
        #1;
        ctl_valid = 1'b0;
        ctl_data  = '0;
    endtask

    // One LRCK half frame, MSB at position 1 and zeros after the LSB
    task automatic send_half(input logic level, input logic [SAMPLE_W-1:0] sample);
        for (int pos = 0; pos < HALF_CYCLES; pos++) begin
            @(posedge adc_pbck);
            #1;
            adc_plrck = level;
            if (pos >= 1 && pos <= SAMPLE_W) begin
                adc_pdata = sample[SAMPLE_W-pos];
            end else begin
                adc_pdata = 1'b0;
            end
        end
    endtask

    task automatic send_frame(input logic [SAMPLE_W-1:0] left,
                              input logic [SAMPLE_W-1:0] right);
        send_half(1'b0, left);
        send_half(1'b1, right);
    endtask

    // Admitted samples come out zero-extended
    task automatic expect_pair(input logic [SAMPLE_W-1:0] left,
                               input logic [SAMPLE_W-1:0] right);
        exp_q.push_back({{PAD_W{1'b0}}, left});
        exp_q.push_back({{PAD_W{1'b0}}, right});
    endtask

    // Received words must follow the expected stream in order
    task automatic compare_stream();
        logic [AUDIO_WORD_W-1:0] got;
        while (got_q.size() > 0) begin
            got = got_q.pop_front();
            if (exp_q.size() == 0) begin
                fail_run($sformatf("Received word %h that was never expected", got));
            end else begin
                check_value("aud_data", got, exp_q.pop_front());
            end
        end
    endtask

    initial begin
        int received;
        adc_pbck  = 1'b0;
        reset     = 1'b1;
        ctl_valid = 1'b0;
        ctl_data  = '0;
        adc_plrck = 1'b1;
        adc_pdata = 1'b0;
        aud_ready = 1'b1;
        seed      = 63382;

        // Corner pairs first, random pairs after
        stim_left[0]  = 24'hFFFFFF;
        stim_right[0] = 24'hFFFFFF;
        stim_left[1]  = 24'hAAAAAA;
        stim_right[1] = 24'h555555;
        stim_left[2]  = 24'h800000;
        stim_right[2] = 24'h800000;
        stim_left[3]  = 24'h000001;
        stim_right[3] = 24'h000001;
        stim_left[4]  = 24'h000000;
        stim_right[4] = 24'h000000;
        for (int i = 5; i < NUM_PAIRS; i++) begin
            stim_left[i]  = SAMPLE_W'($random(seed));
            stim_right[i] = SAMPLE_W'($random(seed));
        end

        repeat (5) @(posedge adc_pbck);
        #1;
        reset = 1'b0;
        check_value("aud_valid", aud_valid, 0);
        check_value("overflow", overflow, 0);
        check_value("acon", acon, ACON_RESET);

        // Gate is closed so nothing may reach the output
        send_frame(stim_left[0], stim_right[0]);
        wait_cycles(8);
        check_value("words before start", got_q.size(), 0);

        send_byte(CMD_START_RECORDING);
        end_cmd();
        for (int i = 0; i < NUM_PAIRS; i++) begin
            expect_pair(stim_left[i], stim_right[i]);
            send_frame(stim_left[i], stim_right[i]);
        end
        wait_fifo_empty();
        received = got_q.size();
        // The first pair after the command may be refused as a whole
        if (received == 2 * NUM_PAIRS - 3) begin
            void'(exp_q.pop_front());
            void'(exp_q.pop_front());
        end else begin
            check_value("recorded word count", received, 2 * NUM_PAIRS - 1);
        end
        compare_stream();

        send_byte(CMD_SET_ACON);
        send_byte(8'hA7);
        end_cmd();
        check_value("acon", acon, 8'hA7);
        send_byte(8'h3C);
        end_cmd();
        check_value("acon", acon, 8'hA7);
        // Decoder should be back at a command byte
        send_byte(CMD_SET_ACON);
        send_byte(8'h5E);
        end_cmd();
        check_value("acon", acon, 8'h5E);
        check_value("overflow", overflow, 0);

        // Pending right word drains first, then the sink stalls
        send_half(1'b0, stim_left[0]);
        compare_stream();
        check_value("pending words", exp_q.size(), 0);
        aud_ready = 1'b0;
        expect_pair(stim_left[0], stim_right[0]);
        send_half(1'b1, stim_right[0]);
        for (int i = 1; i < 9; i++) begin
            expect_pair(stim_left[i % NUM_PAIRS], stim_right[i % NUM_PAIRS]);
            send_frame(stim_left[i % NUM_PAIRS], stim_right[i % NUM_PAIRS]);
        end
        check_value("overflow", overflow, 1);

        send_byte(CMD_STOP_RECORDING);
        end_cmd();
        for (int i = 0; i < 3; i++) begin
            send_frame(stim_left[i], stim_right[i]);
        end
        aud_ready = 1'b1;
        while (got_q.size() < FIFO_DEPTH) begin
            @(posedge adc_pbck);
            #1;
        end
        wait_fifo_empty();
        check_value("drained word count", got_q.size(), FIFO_DEPTH);
        compare_stream();
        // Last stalled pair was lost in the full FIFO
        exp_q.delete();

        send_frame(stim_left[3], stim_right[3]);
        send_frame(stim_left[4], stim_right[4]);
        wait_cycles(4);
        check_value("words after stop", got_q.size(), 0);
        check_value("aud_valid", aud_valid, 0);
        check_value("overflow", overflow, 1);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hw/slot_adc_pkg.sv
hw/i2s_capture.sv
hw/record_gate.sv
hw/sample_fifo.sv
hw/slot_cmd_decoder.sv
hw/slot_adc_rx.sv
tests/slot_adc_rx_checker.sv
tests/slot_adc_rx_tb.sv

// File: Bender.yml
package:
  name: slot_adc_rx

sources:
  - hw/slot_adc_pkg.sv
  - hw/i2s_capture.sv
  - hw/record_gate.sv
  - hw/sample_fifo.sv
  - hw/slot_cmd_decoder.sv
  - hw/slot_adc_rx.sv
  - target: test
    files:
      - tests/slot_adc_rx_checker.sv
      - tests/slot_adc_rx_tb.sv
